/* Bender.yml */
package:
  name: msi_gen

sources:
  - include_dirs:
      - logic
    files:
      - logic/msi_pkg.sv
      - logic/msi_msg_if.sv
      - logic/msi_irq_arbiter.sv
      - logic/msi_encoder.sv
      - logic/msi_axil_initiator.sv
      - logic/msi_gen_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/msi_gen_assertions.sv
      - testbench/msi_gen_tb.sv

/* list.f */
+incdir+logic
logic/msi_pkg.sv
logic/msi_msg_if.sv
logic/msi_irq_arbiter.sv
logic/msi_encoder.sv
logic/msi_axil_initiator.sv
logic/msi_gen_top.sv
testbench/msi_gen_assertions.sv
testbench/msi_gen_tb.sv

/* logic/msi_axil_initiator.sv */
/*
 * AXI4-Lite write-only initiator for MSI messages
 * Independent AW and W beats, B wait, sticky error flag
 */

`timescale 1ns/1ps

`include "msi_config.svh"

module msi_axil_initiator (
  input  logic                       clk,
  input  logic                       rst,
  msi_msg_if.dst                     msg,
  output logic [`MSI_ADDR_WIDTH-1:0] awaddr,
  output logic                       awvalid,
  input  logic                       awready,
  output logic [`MSI_DATA_WIDTH-1:0] wdata,
  output logic [`MSI_STRB_WIDTH-1:0] wstrb,
  output logic                       wvalid,
  input  logic                       wready,
  input  msi_pkg::axi_resp_e         bresp,
  input  logic                       bvalid,
  output logic                       bready,
  output logic                       error
);

  msi_pkg::init_state_e state;
  msi_pkg::init_state_e state_nxt;
  logic                 msg_xfer;
  logic                 aw_done;
  logic                 w_done;

  assign msg.ready = (state == msi_pkg::IDLE);
  assign bready    = (state == msi_pkg::RESP);
  assign msg_xfer  = msg.valid && msg.ready;

  // A channel is finished once its valid has dropped or handshakes now
  assign aw_done = !awvalid || awready;
  assign w_done  = !wvalid || wready;

  always_comb begin
    state_nxt = state;
    unique case (state)
      msi_pkg::IDLE: begin
        if (msg_xfer) begin
          state_nxt = msi_pkg::SEND;
        end
      end
      msi_pkg::SEND: begin
        if (aw_done && w_done) begin
          state_nxt = msi_pkg::RESP;
        end
      end
      msi_pkg::RESP: begin
        if (bvalid) begin
          state_nxt = msi_pkg::IDLE;
        end
      end
      default: state_nxt = msi_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= msi_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Both valids rise together, each drops on its own ready
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else if (msg_xfer) begin
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
    end else begin
      if (awvalid && awready) begin
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (msg_xfer) begin
      awaddr <= msg.addr;
      wdata  <= msg.data;
      wstrb  <= msg.strb;
    end
  end

  // Stays set until reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      error <= 1'b0;
    end else if (bready && bvalid && (bresp != msi_pkg::OKAY)) begin
      error <= 1'b1;
    end
  end

endmodule

/* logic/msi_config.svh */
/*
 * Width and count macros for the interrupt-to-MSI bridge
 */

`ifndef MSI_CONFIG_SVH
`define MSI_CONFIG_SVH

// AXI4-Lite bus geometry
`define MSI_ADDR_WIDTH 40
`define MSI_DATA_WIDTH 64
`define MSI_STRB_WIDTH 8

// Interrupt lines and their per-line IDs
`define MSI_NUM_IRQ 4
`define MSI_IRQ_IDX_WIDTH 2
`define MSI_DEVID_WIDTH 16
`define MSI_EVID_WIDTH 16

// Throttle counter
`define MSI_THR_WIDTH 16

`endif

/* logic/msi_encoder.sv */
/*
 * MSI message formation from the granted interrupt
 * Throttle down-counter spacing successive messages
 */

`timescale 1ns/1ps

`include "msi_config.svh"

module msi_encoder (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              grant_valid,
  input  logic [`MSI_IRQ_IDX_WIDTH-1:0]                     grant_idx,
  output logic                                              grant_ready,
  input  logic [`MSI_ADDR_WIDTH-1:0]                        msi_base_addr,
  input  logic [`MSI_NUM_IRQ-1:0][`MSI_DEVID_WIDTH-1:0]     device_id_per_irq,
  input  logic [`MSI_NUM_IRQ-1:0][`MSI_EVID_WIDTH-1:0]      event_id_per_irq,
  input  logic                                              throttle_en,
  input  logic [`MSI_THR_WIDTH-1:0]                         throttle_cntr_threshold,
  msi_msg_if.src                                            msg
);

  localparam int ADDR_PAD = `MSI_ADDR_WIDTH - `MSI_DEVID_WIDTH - 2;
  localparam int DATA_PAD = `MSI_DATA_WIDTH - `MSI_EVID_WIDTH;
  localparam int STRB_PAD = `MSI_STRB_WIDTH - 4;

  logic                       msg_valid;
  logic [`MSI_ADDR_WIDTH-1:0] msg_addr;
  logic [`MSI_DATA_WIDTH-1:0] msg_data;
  logic [`MSI_STRB_WIDTH-1:0] msg_strb;
  logic [`MSI_THR_WIDTH-1:0]  thr_cnt;
  logic                       grant_xfer;
  logic                       msg_xfer;

  // Slot must be empty and throttle window expired
  assign grant_ready = !msg_valid && (thr_cnt == '0);
  assign grant_xfer  = grant_valid && grant_ready;
  assign msg_xfer    = msg_valid && msg.ready;

  assign msg.valid = msg_valid;
  assign msg.addr  = msg_addr;
  assign msg.data  = msg_data;
  assign msg.strb  = msg_strb;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      msg_valid <= 1'b0;
    end else if (grant_xfer) begin
      msg_valid <= 1'b1;
    end else if (msg_xfer) begin
      msg_valid <= 1'b0;
    end
  end

  // Address is base plus 4 times the device ID, data is the event ID
  always_ff @(posedge clk) begin
    if (grant_xfer) begin
      msg_addr <= msi_base_addr +
                  {{ADDR_PAD{1'b0}}, device_id_per_irq[grant_idx], 2'b00};
      msg_data <= {{DATA_PAD{1'b0}}, event_id_per_irq[grant_idx]};
      msg_strb <= {{STRB_PAD{1'b0}}, 4'hF};
    end
  end

  // Loaded when a message leaves, then runs down to zero
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      thr_cnt <= '0;
    end else if (msg_xfer && throttle_en && (throttle_cntr_threshold != '0)) begin
      thr_cnt <= throttle_cntr_threshold - 1'b1;
    end else if (thr_cnt != '0) begin
      thr_cnt <= thr_cnt - 1'b1;
    end
  end

endmodule

/* logic/msi_gen_top.sv */
/*
 * Interrupt-to-MSI bridge top level
 * Arbiter, encoder and AXI4-Lite initiator
 */

`timescale 1ns/1ps

`include "msi_config.svh"

module msi_gen_top (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [`MSI_NUM_IRQ-1:0]                       irq,
  input  logic [`MSI_NUM_IRQ-1:0]                       msi_enable,
  input  logic [`MSI_ADDR_WIDTH-1:0]                    msi_base_addr,
  input  logic [`MSI_NUM_IRQ-1:0][`MSI_DEVID_WIDTH-1:0] device_id_per_irq,
  input  logic [`MSI_NUM_IRQ-1:0][`MSI_EVID_WIDTH-1:0]  event_id_per_irq,
  input  logic                                          throttle_en,
  input  logic [`MSI_THR_WIDTH-1:0]                     throttle_cntr_threshold,
  output logic [`MSI_ADDR_WIDTH-1:0]                    awaddr,
  output logic                                          awvalid,
  input  logic                                          awready,
  output logic [`MSI_DATA_WIDTH-1:0]                    wdata,
  output logic [`MSI_STRB_WIDTH-1:0]                    wstrb,
  output logic                                          wvalid,
  input  logic                                          wready,
  input  msi_pkg::axi_resp_e                            bresp,
  input  logic                                          bvalid,
  output logic                                          bready,
  output logic                                          error
);

  logic                          grant_valid;
  logic [`MSI_IRQ_IDX_WIDTH-1:0] grant_idx;
  logic                          grant_ready;

  msi_msg_if msg_if ();

  msi_irq_arbiter arbiter_inst (
    .clk         (clk),
    .rst         (rst),
    .irq         (irq),
    .msi_enable  (msi_enable),
    .grant_valid (grant_valid),
    .grant_idx   (grant_idx),
    .grant_ready (grant_ready)
  );

  msi_encoder encoder_inst (
    .clk                     (clk),
    .rst                     (rst),
    .grant_valid             (grant_valid),
    .grant_idx               (grant_idx),
    .grant_ready             (grant_ready),
    .msi_base_addr           (msi_base_addr),
    .device_id_per_irq       (device_id_per_irq),
    .event_id_per_irq        (event_id_per_irq),
    .throttle_en             (throttle_en),
    .throttle_cntr_threshold (throttle_cntr_threshold),
    .msg                     (msg_if.src)
  );

  msi_axil_initiator initiator_inst (
    .clk     (clk),
    .rst     (rst),
    .msg     (msg_if.dst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .error   (error)
  );

endmodule

/* logic/msi_irq_arbiter.sv */
/*
 * Interrupt edge detection with pending bits
 * Round-robin selection of one pending interrupt
 */

`timescale 1ns/1ps

`include "msi_config.svh"

module msi_irq_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`MSI_NUM_IRQ-1:0]       irq,
  input  logic [`MSI_NUM_IRQ-1:0]       msi_enable,
  output logic                          grant_valid,
  output logic [`MSI_IRQ_IDX_WIDTH-1:0] grant_idx,
  input  logic                          grant_ready
);

  logic [`MSI_NUM_IRQ-1:0]       irq_q;
  logic [`MSI_NUM_IRQ-1:0]       rise;
  logic [`MSI_NUM_IRQ-1:0]       pending;
  logic [`MSI_NUM_IRQ-1:0]       clr;
  logic [`MSI_IRQ_IDX_WIDTH-1:0] rr_ptr;
  logic [`MSI_IRQ_IDX_WIDTH-1:0] cand;
  logic                          xfer;

  // Only enabled lines can raise a request
  assign rise = irq & ~irq_q & msi_enable;
  assign xfer = grant_valid && grant_ready;

  always_comb begin
    clr = '0;
    if (xfer) begin
      clr[grant_idx] = 1'b1;
    end
  end

  // Search from the pointer upward, the pointer slot wins
  always_comb begin
    grant_valid = 1'b0;
    grant_idx   = '0;
    cand        = '0;
    for (int k = `MSI_NUM_IRQ - 1; k >= 0; k--) begin
      cand = rr_ptr + k[`MSI_IRQ_IDX_WIDTH-1:0];
      if (pending[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq;
    end
  end

  // A rise on an already pending line merges into the same bit
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr) | rise;
    end
  end

  // Next search starts just above the last winner
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (xfer) begin
      rr_ptr <= grant_idx + 1'b1;
    end
  end

endmodule

/* logic/msi_msg_if.sv */
/*
 * Encoded MSI message handshake between encoder and initiator
 */

`timescale 1ns/1ps

`include "msi_config.svh"

interface msi_msg_if;

  logic                       valid;
  logic                       ready;
  logic [`MSI_ADDR_WIDTH-1:0] addr;
  logic [`MSI_DATA_WIDTH-1:0] data;
  logic [`MSI_STRB_WIDTH-1:0] strb;

  // Message producer
  modport src (
    output valid,
    output addr,
    output data,
    output strb,
    input  ready
  );

  // Message consumer, drives only ready
  modport dst (
    input  valid,
    input  addr,
    input  data,
    input  strb,
    output ready
  );

endinterface

/* logic/msi_pkg.sv */
/*
 * Shared types for the MSI bridge
 * AXI write response codes and initiator FSM states
 */

package msi_pkg;

  // AXI response codes as carried on BRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Initiator sequencing
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    SEND = 2'b01,
    RESP = 2'b10
  } init_state_e;

endpackage

/* testbench/msi_gen_assertions.sv */
/*
 * Bound AXI4-Lite checks for the MSI bridge
 * Encoded address, data and strobe, throttle spacing
 */

`timescale 1ns/1ps

`include "msi_config.svh"

module msi_gen_assertions (
  input logic                                          clk,
  input logic                                          rst,
  input logic [`MSI_ADDR_WIDTH-1:0]                    msi_base_addr,
  input logic [`MSI_NUM_IRQ-1:0][`MSI_DEVID_WIDTH-1:0] device_id_per_irq,
  input logic [`MSI_NUM_IRQ-1:0][`MSI_EVID_WIDTH-1:0]  event_id_per_irq,
  input logic                                          throttle_en,
  input logic [`MSI_THR_WIDTH-1:0]                     throttle_cntr_threshold,
  input logic [`MSI_ADDR_WIDTH-1:0]                    awaddr,
  input logic                                          awvalid,
  input logic [`MSI_DATA_WIDTH-1:0]                    wdata,
  input logic [`MSI_STRB_WIDTH-1:0]                    wstrb,
  input logic                                          wvalid
);

  int                       fail_count;
  logic                     addr_hit;
  logic                     data_hit;
  logic                     aw_q;
  logic                     aw_rise;
  logic                     seen_rise;
  logic [`MSI_THR_WIDTH:0]  since_rise;

  // Match against every configured line
  always_comb begin
    addr_hit = 1'b0;
    data_hit = 1'b0;
    for (int i = 0; i < `MSI_NUM_IRQ; i++) begin
      if (awaddr == msi_base_addr + {device_id_per_irq[i], 2'b00}) begin
        addr_hit = 1'b1;
      end
      if (wdata == {{(`MSI_DATA_WIDTH-`MSI_EVID_WIDTH){1'b0}}, event_id_per_irq[i]}) begin
        data_hit = 1'b1;
      end
    end
  end

  assign aw_rise = awvalid && !aw_q;

  // Cycles since the last awvalid rise, saturating
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      aw_q       <= 1'b0;
      seen_rise  <= 1'b0;
      since_rise <= '0;
    end else begin
      aw_q <= awvalid;
      if (aw_rise) begin
        seen_rise  <= 1'b1;
        since_rise <= 1;
      end else if (!(&since_rise)) begin
        since_rise <= since_rise + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) awvalid |-> addr_hit)
    else begin
      $error("awaddr %h matches no configured device ID", awaddr);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
                   wvalid |-> (data_hit && (wstrb == 8'h0F)))
    else begin
      $error("wdata %h or wstrb %h is not a configured encoding", wdata, wstrb);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
                   (aw_rise && seen_rise && throttle_en) |->
                   (since_rise >= throttle_cntr_threshold))
    else begin
      $error("awvalid rose %0d cycles after the previous rise", since_rise);
      fail_count++;
    end

endmodule

bind msi_gen_top msi_gen_assertions axi_checks_inst (
  .clk                     (clk),
  .rst                     (rst),
  .msi_base_addr           (msi_base_addr),
  .device_id_per_irq       (device_id_per_irq),
  .event_id_per_irq        (event_id_per_irq),
  .throttle_en             (throttle_en),
  .throttle_cntr_threshold (throttle_cntr_threshold),
  .awaddr                  (awaddr),
  .awvalid                 (awvalid),
  .wdata                   (wdata),
  .wstrb                   (wstrb),
  .wvalid                  (wvalid)
);

/* testbench/msi_gen_golden.txt */
# T name enable base throttle_en threshold bresp / D device IDs 0..3 / V event IDs 0..3
# P irq pulse mask / E expected awaddr wdata wstrb in order; hex except the three decimals
T single f 0080001000 0 0 0
D 0010 0021 0032 0043
V 1001 1002 1003 1004
P 2
E 0080001084 0000000000001002 0f
T rr_order f 0080001000 0 0 0
D 0010 0021 0032 0043
V 1001 1002 1003 1004
P 2
P f
E 0080001084 0000000000001002 0f
E 00800010c8 0000000000001003 0f
E 008000110c 0000000000001004 0f
E 0080001040 0000000000001001 0f
E 0080001084 0000000000001002 0f
T masked b 0080001000 0 0 0
D 0010 0021 0032 0043
V 1001 1002 1003 1004
P 4
P 8
E 008000110c 0000000000001004 0f
T throttle f 00fee00000 1 20 0
D 0001 0002 0003 0004
V 0020 0021 0022 0023
P f
E 00fee00004 0000000000000020 0f
E 00fee00008 0000000000000021 0f
E 00fee0000c 0000000000000022 0f
E 00fee00010 0000000000000023 0f
T slverr f 0080001000 0 0 2
D 0010 0021 0032 0043
V 1001 1002 1003 1004
P 1
P 2
E 0080001040 0000000000001001 0f
E 0080001084 0000000000001002 0f
T mixed f 7fffff0000 0 0 0
D ffff 8000 0001 1234
V ffff 8001 00a5 5a5a
P 5
P a
P f
E 800002fffc 000000000000ffff 0f
E 8000010000 0000000000008001 0f
E 7fffff0004 00000000000000a5 0f
E 7fffff48d0 0000000000005a5a 0f
E 800002fffc 000000000000ffff 0f
E 8000010000 0000000000008001 0f

/* testbench/msi_gen_tb.sv */
/*
 * Testbench for the interrupt-to-MSI bridge
 * Golden-file stimulus, AXI4-Lite target model with random delays, checks, watchdog
 */

`timescale 1ns/1ps

`include "msi_config.svh"

module msi_gen_tb;

  localparam int MAX_TESTS       = 8;
  localparam int MAX_PULSES      = 8;
  localparam int MAX_WRITES      = 16;
  localparam int QUIET_CYCLES    = 60;
  localparam int CYCLES_PER_TEST = 2000;

  logic                                          clk;
  logic                                          rst;
  logic [`MSI_NUM_IRQ-1:0]                       irq;
  logic [`MSI_NUM_IRQ-1:0]                       msi_enable;
  logic [`MSI_ADDR_WIDTH-1:0]                    msi_base_addr;
  logic [`MSI_NUM_IRQ-1:0][`MSI_DEVID_WIDTH-1:0] device_id_per_irq;
  logic [`MSI_NUM_IRQ-1:0][`MSI_EVID_WIDTH-1:0]  event_id_per_irq;
  logic                                          throttle_en;
  logic [`MSI_THR_WIDTH-1:0]                     throttle_cntr_threshold;
  logic [`MSI_ADDR_WIDTH-1:0]                    awaddr;
  logic                                          awvalid;
  logic                                          awready;
  logic [`MSI_DATA_WIDTH-1:0]                    wdata;
  logic [`MSI_STRB_WIDTH-1:0]                    wstrb;
  logic                                          wvalid;
  logic                                          wready;
  msi_pkg::axi_resp_e                            bresp;
  logic                                          bvalid;
  logic                                          bready;
  logic                                          error;

  // Golden records, one row per test
  logic [8*16-1:0]             t_name   [MAX_TESTS];
  logic [`MSI_NUM_IRQ-1:0]     t_enable [MAX_TESTS];
  logic [`MSI_ADDR_WIDTH-1:0]  t_base   [MAX_TESTS];
  logic                        t_thr_en [MAX_TESTS];
  logic [`MSI_THR_WIDTH-1:0]   t_thr    [MAX_TESTS];
  logic [1:0]                  t_resp   [MAX_TESTS];
  logic [`MSI_DEVID_WIDTH-1:0] t_dev    [MAX_TESTS][`MSI_NUM_IRQ];
  logic [`MSI_EVID_WIDTH-1:0]  t_evt    [MAX_TESTS][`MSI_NUM_IRQ];
  int                          t_npulse [MAX_TESTS];
  logic [`MSI_NUM_IRQ-1:0]     t_pulse  [MAX_TESTS][MAX_PULSES];
  int                          t_nexp   [MAX_TESTS];
  logic [`MSI_ADDR_WIDTH-1:0]  e_addr   [MAX_TESTS][MAX_WRITES];
  logic [`MSI_DATA_WIDTH-1:0]  e_data   [MAX_TESTS][MAX_WRITES];
  logic [`MSI_STRB_WIDTH-1:0]  e_strb   [MAX_TESTS][MAX_WRITES];

  int              num_tests;
  int              tidx;
  logic [8*16-1:0] cur_name;
  logic            tests_loaded;
  int              error_count;

  // Target model state
  int   aw_cnt;
  int   w_cnt;
  int   b_cnt;
  int   cyc;
  int   last_rise;
  logic aw_prev;
  logic seen_rise;
  logic need_b;
  int   r_aw;
  int   r_w;
  int   r_b;

  msi_gen_top msi_gen_top_inst (
    .clk                     (clk),
    .rst                     (rst),
    .irq                     (irq),
    .msi_enable              (msi_enable),
    .msi_base_addr           (msi_base_addr),
    .device_id_per_irq       (device_id_per_irq),
    .event_id_per_irq        (event_id_per_irq),
    .throttle_en             (throttle_en),
    .throttle_cntr_threshold (throttle_cntr_threshold),
    .awaddr                  (awaddr),
    .awvalid                 (awvalid),
    .awready                 (awready),
    .wdata                   (wdata),
    .wstrb                   (wstrb),
    .wvalid                  (wvalid),
    .wready                  (wready),
    .bresp                   (bresp),
    .bvalid                  (bvalid),
    .bready                  (bready),
    .error                   (error)
  );

  always #20 clk = ~clk;

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_problem(input string why);
    error_count++;
    $display("ERROR: %s (test %0s)", why, cur_name);
    abort_run();
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("FAILED %0s %s: expected %h, actual %h", cur_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic load_golden();
    int               fd;
    int               n;
    int               t;
    logic [7:0]       tag;
    logic [8*128-1:0] skip;
    fd = $fopen("testbench/msi_gen_golden.txt", "r");
    if (fd == 0) begin
      report_problem("cannot open testbench/msi_gen_golden.txt");
    end
    num_tests = 0;
    t = 0;
    n = $fscanf(fd, "%s", tag);
    while (n == 1) begin
      case (tag)
        "#": n = $fgets(skip, fd);
        "T": begin
          t = num_tests;
          num_tests++;
          n = $fscanf(fd, "%s %h %h %d %d %d", t_name[t], t_enable[t], t_base[t],
                      t_thr_en[t], t_thr[t], t_resp[t]);
          t_npulse[t] = 0;
          t_nexp[t]   = 0;
        end
        "D": n = $fscanf(fd, "%h %h %h %h", t_dev[t][0], t_dev[t][1], t_dev[t][2],
                         t_dev[t][3]);
        "V": n = $fscanf(fd, "%h %h %h %h", t_evt[t][0], t_evt[t][1], t_evt[t][2],
                         t_evt[t][3]);
        "P": begin
          n = $fscanf(fd, "%h", t_pulse[t][t_npulse[t]]);
          t_npulse[t]++;
        end
        "E": begin
          n = $fscanf(fd, "%h %h %h", e_addr[t][t_nexp[t]], e_data[t][t_nexp[t]],
                      e_strb[t][t_nexp[t]]);
          t_nexp[t]++;
        end
        default: report_problem("unknown record tag in the golden file");
      endcase
      n = $fscanf(fd, "%s", tag);
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int t);
    int i;
    int p;
    @(negedge clk);
    rst                     = 1'b1;
    tidx                    = t;
    cur_name                = t_name[t];
    msi_enable              = t_enable[t];
    msi_base_addr           = t_base[t];
    throttle_en             = t_thr_en[t];
    throttle_cntr_threshold = t_thr[t];
    bresp                   = msi_pkg::axi_resp_e'(t_resp[t]);
    for (i = 0; i < `MSI_NUM_IRQ; i++) begin
      device_id_per_irq[i] = t_dev[t][i];
      event_id_per_irq[i]  = t_evt[t][i];
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // One-cycle pulses, one idle cycle between them
    for (p = 0; p < t_npulse[t]; p++) begin
      @(negedge clk);
      irq = t_pulse[t][p];
      @(negedge clk);
      irq = '0;
    end
    while (b_cnt < t_nexp[t]) begin
      @(negedge clk);
    end
    // Window for a late extra write to show up
    repeat (QUIET_CYCLES) @(negedge clk);
    check_value("write count", t_nexp[t], aw_cnt);
    check_value("data beat count", t_nexp[t], w_cnt);
    check_value("error flag", t_resp[t] != 2'b00, error);
  endtask

  // Capture beats and responses at the rising edge
  always @(posedge clk) begin
    if (rst) begin
      aw_cnt    = 0;
      w_cnt     = 0;
      b_cnt     = 0;
      cyc       = 0;
      last_rise = 0;
      aw_prev   = 1'b0;
      seen_rise = 1'b0;
    end else begin
      cyc = cyc + 1;
      if (awvalid && !aw_prev) begin
        if (seen_rise && throttle_en && (cyc - last_rise < throttle_cntr_threshold)) begin
          report_problem($sformatf("awvalid rose %0d cycles after the previous rise",
                                   cyc - last_rise));
        end
        seen_rise = 1'b1;
        last_rise = cyc;
      end
      aw_prev = awvalid;
      if (awvalid && awready) begin
        if (aw_cnt >= t_nexp[tidx]) begin
          report_problem("address beat beyond the expected list of writes");
        end
        check_value("awaddr", e_addr[tidx][aw_cnt], awaddr);
        aw_cnt++;
      end
      if (wvalid && wready) begin
        if (w_cnt >= t_nexp[tidx]) begin
          report_problem("data beat beyond the expected list of writes");
        end
        check_value("wdata", e_data[tidx][w_cnt], wdata);
        check_value("wstrb", e_strb[tidx][w_cnt], wstrb);
        w_cnt++;
      end
      // bready only once both beats are done and the response is still owed
      if (bready && !((aw_cnt == w_cnt) && (aw_cnt > b_cnt))) begin
        report_problem("bready high with no write response outstanding");
      end
      if (bvalid && bready) begin
        b_cnt++;
      end
    end
  end

  // Random ready and response delays
  always @(negedge clk) begin
    r_aw    = $urandom % 3;
    r_w     = $urandom % 3;
    r_b     = $urandom % 4;
    awready = !rst && (r_aw != 0);
    wready  = !rst && (r_w != 0);
    need_b  = (aw_cnt == w_cnt) && (aw_cnt > b_cnt);
    if (rst || !need_b) begin
      bvalid = 1'b0;
    end else if (!bvalid) begin
      bvalid = (r_b == 0);
    end
  end

  always @(negedge clk) begin
    if (msi_gen_top_inst.axi_checks_inst.fail_count != 0) begin
      report_problem("a bound AXI assertion failed");
    end
  end

  initial begin
    wait (tests_loaded);
    repeat (num_tests * CYCLES_PER_TEST) @(posedge clk);
    report_problem("watchdog expired before all tests finished");
  end

  initial begin
    int t;
    clk                     = 1'b0;
    rst                     = 1'b1;
    irq                     = '0;
    msi_enable              = '0;
    msi_base_addr           = '0;
    device_id_per_irq       = '0;
    event_id_per_irq        = '0;
    throttle_en             = 1'b0;
    throttle_cntr_threshold = '0;
    awready                 = 1'b0;
    wready                  = 1'b0;
    bvalid                  = 1'b0;
    bresp                   = msi_pkg::OKAY;
    tidx                    = 0;
    cur_name                = "setup";
    error_count             = 0;
    tests_loaded            = 1'b0;
    void'($urandom(32'h2f32));
    load_golden();
    tests_loaded = 1'b1;
    for (t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    if (error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule
